/* Bender.yml */
package:
  name: mycpu

export_include_dirs:
  - src

sources:
  - src/mycpu_pkg.sv
  - src/reg_file.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/result_stage.sv
  - src/mycpu_top.sv
  - target: test
    files:
      - tb/mycpu_chk.sv
      - tb/tb_mycpu.sv

/* mycpu_top.f */
+incdir+src
src/mycpu_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/mycpu_top.sv
tb/mycpu_chk.sv
tb/tb_mycpu.sv

/* src/decode_stage.sv */
`include "mycpu_defines.svh"

module decode_stage (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  mycpu_pkg::fetch_t        in_item,
  output logic                     allowin,
  output logic                     out_valid,
  output mycpu_pkg::exec_t         out_item,
  input  logic                     out_allowin,
  output logic [`MYCPU_REG_AW-1:0] rs_num,
  output logic [`MYCPU_REG_AW-1:0] rt_num,
  input  logic [`MYCPU_XLEN-1:0]   rs_data,
  input  logic [`MYCPU_XLEN-1:0]   rt_data,
  input  mycpu_pkg::fwd_t          ex_fwd,
  input  mycpu_pkg::fwd_t          rs_fwd
);

  logic                   valid;
  mycpu_pkg::fetch_t      item_q;
  mycpu_pkg::instr_u      w;
  logic [`MYCPU_XLEN-1:0] rs_val;
  logic [`MYCPU_XLEN-1:0] rt_val;
  logic [`MYCPU_XLEN-1:0] imm_sx;
  logic [`MYCPU_XLEN-1:0] imm_zx;
  logic [`MYCPU_XLEN-1:0] imm_up;
  logic [`MYCPU_XLEN-1:0] shamt_zx;

  // execute first, then result, then register file
  function automatic logic [`MYCPU_XLEN-1:0] pick(
    input logic [`MYCPU_REG_AW-1:0] num,
    input logic [`MYCPU_XLEN-1:0]   rf_val
  );
    if (ex_fwd.valid && ex_fwd.num == num) return ex_fwd.data;
    if (rs_fwd.valid && rs_fwd.num == num) return rs_fwd.data;
    return rf_val;
  endfunction

  assign allowin   = !valid || out_allowin;
  assign out_valid = valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (allowin) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && allowin) begin
      item_q <= in_item;
    end
  end

  assign w      = item_q.instr;
  assign rs_num = w.r.rs;
  assign rt_num = w.r.rt;

  always_comb begin
    rs_val = pick(w.r.rs, rs_data);
    rt_val = pick(w.r.rt, rt_data);
  end

  assign imm_sx   = {{(`MYCPU_XLEN-16){w.i.imm[15]}}, w.i.imm};
  assign imm_zx   = {{(`MYCPU_XLEN-16){1'b0}}, w.i.imm};
  assign imm_up   = {w.i.imm, 16'h0000};
  assign shamt_zx = {{(`MYCPU_XLEN-`MYCPU_SHAMT_W){1'b0}}, w.r.shamt};

  always_comb begin
    out_item.pc     = item_q.pc;
    out_item.alu_op = mycpu_pkg::alu_add;
    out_item.src_a  = rs_val;
    out_item.src_b  = rt_val;
    out_item.dest   = w.r.rd;
    out_item.wr     = 1'b1;
    if (w.r.op == `MYCPU_OP_SPECIAL) begin
      // shifts take the amount on a, the value on b
      case (w.r.funct)
        `MYCPU_FN_ADDU: out_item.alu_op = mycpu_pkg::alu_add;
        `MYCPU_FN_SUBU: out_item.alu_op = mycpu_pkg::alu_sub;
        `MYCPU_FN_AND:  out_item.alu_op = mycpu_pkg::alu_and;
        `MYCPU_FN_OR:   out_item.alu_op = mycpu_pkg::alu_or;
        `MYCPU_FN_XOR:  out_item.alu_op = mycpu_pkg::alu_xor;
        `MYCPU_FN_NOR:  out_item.alu_op = mycpu_pkg::alu_nor;
        `MYCPU_FN_SLT:  out_item.alu_op = mycpu_pkg::alu_slt;
        `MYCPU_FN_SLTU: out_item.alu_op = mycpu_pkg::alu_sltu;
        `MYCPU_FN_SLL: begin
          out_item.alu_op = mycpu_pkg::alu_sll;
          out_item.src_a  = shamt_zx;
        end
        `MYCPU_FN_SRL: begin
          out_item.alu_op = mycpu_pkg::alu_srl;
          out_item.src_a  = shamt_zx;
        end
        `MYCPU_FN_SRA: begin
          out_item.alu_op = mycpu_pkg::alu_sra;
          out_item.src_a  = shamt_zx;
        end
        default: out_item.wr = 1'b0;
      endcase
    end else begin
      out_item.dest  = w.i.rt;
      out_item.src_b = imm_sx;
      case (w.i.op)
        `MYCPU_OP_ADDIU: out_item.alu_op = mycpu_pkg::alu_add;
        `MYCPU_OP_SLTI:  out_item.alu_op = mycpu_pkg::alu_slt;
        `MYCPU_OP_SLTIU: out_item.alu_op = mycpu_pkg::alu_sltu;
        `MYCPU_OP_ANDI: begin
          out_item.alu_op = mycpu_pkg::alu_and;
          out_item.src_b  = imm_zx;
        end
        `MYCPU_OP_ORI: begin
          out_item.alu_op = mycpu_pkg::alu_or;
          out_item.src_b  = imm_zx;
        end
        `MYCPU_OP_XORI: begin
          out_item.alu_op = mycpu_pkg::alu_xor;
          out_item.src_b  = imm_zx;
        end
        `MYCPU_OP_LUI: begin
          // lui is 0 | (imm << 16)
          out_item.alu_op = mycpu_pkg::alu_or;
          out_item.src_a  = '0;
          out_item.src_b  = imm_up;
        end
        default: out_item.wr = 1'b0;
      endcase
    end
  end

endmodule

/* src/execute_stage.sv */
`include "mycpu_defines.svh"

module execute_stage (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  mycpu_pkg::exec_t    in_item,
  output logic                allowin,
  output logic                out_valid,
  output mycpu_pkg::retire_t  out_item,
  input  logic                out_allowin,
  output mycpu_pkg::fwd_t     fwd
);

  logic                      valid;
  mycpu_pkg::exec_t          ex_q;
  logic [`MYCPU_XLEN-1:0]    res;
  logic [`MYCPU_SHAMT_W-1:0] sa;
  logic                      writes;

  assign allowin   = !valid || out_allowin;
  assign out_valid = valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (allowin) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && allowin) begin
      ex_q <= in_item;
    end
  end

  assign sa = ex_q.src_a[`MYCPU_SHAMT_W-1:0];

  always_comb begin
    case (ex_q.alu_op)
      mycpu_pkg::alu_add:  res = ex_q.src_a + ex_q.src_b;
      mycpu_pkg::alu_sub:  res = ex_q.src_a - ex_q.src_b;
      mycpu_pkg::alu_and:  res = ex_q.src_a & ex_q.src_b;
      mycpu_pkg::alu_or:   res = ex_q.src_a | ex_q.src_b;
      mycpu_pkg::alu_xor:  res = ex_q.src_a ^ ex_q.src_b;
      mycpu_pkg::alu_nor:  res = ~(ex_q.src_a | ex_q.src_b);
      mycpu_pkg::alu_slt:
        res = {{(`MYCPU_XLEN-1){1'b0}}, $signed(ex_q.src_a) < $signed(ex_q.src_b)};
      mycpu_pkg::alu_sltu:
        res = {{(`MYCPU_XLEN-1){1'b0}}, ex_q.src_a < ex_q.src_b};
      mycpu_pkg::alu_sll:  res = ex_q.src_b << sa;
      mycpu_pkg::alu_srl:  res = ex_q.src_b >> sa;
      mycpu_pkg::alu_sra:  res = $signed(ex_q.src_b) >>> sa;
      default:             res = '0;
    endcase
  end

  // writes to r0 are dropped here
  assign writes = ex_q.wr && ex_q.dest != '0;

  always_comb begin
    out_item.pc       = ex_q.pc;
    out_item.rf_wen   = writes ? '1 : '0;
    out_item.rf_wnum  = ex_q.dest;
    out_item.rf_wdata = res;
  end

  assign fwd.valid = valid && writes;
  assign fwd.num   = ex_q.dest;
  assign fwd.data  = res;

endmodule

/* src/mycpu_defines.svh */
`ifndef MYCPU_DEFINES_SVH
`define MYCPU_DEFINES_SVH

`define MYCPU_XLEN      32
`define MYCPU_REG_AW    5
`define MYCPU_SHAMT_W   5
`define MYCPU_WEN_W     4

// primary opcodes
`define MYCPU_OP_SPECIAL 6'h00
`define MYCPU_OP_ADDIU   6'h09
`define MYCPU_OP_SLTI    6'h0a
`define MYCPU_OP_SLTIU   6'h0b
`define MYCPU_OP_ANDI    6'h0c
`define MYCPU_OP_ORI     6'h0d
`define MYCPU_OP_XORI    6'h0e
`define MYCPU_OP_LUI     6'h0f

// funct field under SPECIAL
`define MYCPU_FN_SLL     6'h00
`define MYCPU_FN_SRL     6'h02
`define MYCPU_FN_SRA     6'h03
`define MYCPU_FN_ADDU    6'h21
`define MYCPU_FN_SUBU    6'h23
`define MYCPU_FN_AND     6'h24
`define MYCPU_FN_OR      6'h25
`define MYCPU_FN_XOR     6'h26
`define MYCPU_FN_NOR     6'h27
`define MYCPU_FN_SLT     6'h2a
`define MYCPU_FN_SLTU    6'h2b

`endif

/* src/mycpu_pkg.sv */
`include "mycpu_defines.svh"

package mycpu_pkg;

  typedef struct packed {
    logic [5:0]                op;
    logic [`MYCPU_REG_AW-1:0]  rs;
    logic [`MYCPU_REG_AW-1:0]  rt;
    logic [`MYCPU_REG_AW-1:0]  rd;
    logic [`MYCPU_SHAMT_W-1:0] shamt;
    logic [5:0]                funct;
  } r_type_t;

  typedef struct packed {
    logic [5:0]               op;
    logic [`MYCPU_REG_AW-1:0] rs;
    logic [`MYCPU_REG_AW-1:0] rt;
    logic [15:0]              imm;
  } i_type_t;

  // same word, two field layouts
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_nor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  typedef struct packed {
    logic [`MYCPU_XLEN-1:0] pc;
    instr_u                 instr;
  } fetch_t;

  typedef struct packed {
    logic [`MYCPU_XLEN-1:0]   pc;
    alu_op_e                  alu_op;
    logic [`MYCPU_XLEN-1:0]   src_a;
    logic [`MYCPU_XLEN-1:0]   src_b;
    logic [`MYCPU_REG_AW-1:0] dest;
    logic                     wr;
  } exec_t;

  typedef struct packed {
    logic [`MYCPU_XLEN-1:0]   pc;
    logic [`MYCPU_WEN_W-1:0]  rf_wen;
    logic [`MYCPU_REG_AW-1:0] rf_wnum;
    logic [`MYCPU_XLEN-1:0]   rf_wdata;
  } retire_t;

  typedef struct packed {
    logic                     valid;
    logic [`MYCPU_REG_AW-1:0] num;
    logic [`MYCPU_XLEN-1:0]   data;
  } fwd_t;

endpackage

/* src/mycpu_top.sv */
module mycpu_top (
  input  logic               aclk,
  input  logic               rst_n,
  input  logic               inst_valid,
  input  mycpu_pkg::fetch_t  inst,
  output logic               inst_allowin,
  output logic               retire_valid,
  output mycpu_pkg::retire_t retire,
  input  logic               retire_ready
);

  mycpu_pkg::exec_t   de_item;
  mycpu_pkg::retire_t ex_item;
  mycpu_pkg::fwd_t    ex_fwd;
  mycpu_pkg::fwd_t    rs_fwd;
  logic               de_valid;
  logic               ex_valid;
  logic               ex_allowin;
  logic               rs_allowin;
  logic               rf_wr_en;
  logic [4:0]         rs_num;
  logic [4:0]         rt_num;
  logic [31:0]        rs_data;
  logic [31:0]        rt_data;

  decode_stage u_decode (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .in_valid    (inst_valid),
    .in_item     (inst),
    .allowin     (inst_allowin),
    .out_valid   (de_valid),
    .out_item    (de_item),
    .out_allowin (ex_allowin),
    .rs_num      (rs_num),
    .rt_num      (rt_num),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .ex_fwd      (ex_fwd),
    .rs_fwd      (rs_fwd)
  );

  execute_stage u_execute (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .in_valid    (de_valid),
    .in_item     (de_item),
    .allowin     (ex_allowin),
    .out_valid   (ex_valid),
    .out_item    (ex_item),
    .out_allowin (rs_allowin),
    .fwd         (ex_fwd)
  );

  result_stage u_result (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .in_valid     (ex_valid),
    .in_item      (ex_item),
    .allowin      (rs_allowin),
    .retire_valid (retire_valid),
    .retire       (retire),
    .retire_ready (retire_ready),
    .fwd          (rs_fwd),
    .wr_en        (rf_wr_en)
  );

  // commits at the retire transfer
  reg_file u_reg_file (
    .aclk    (aclk),
    .wr_en   (rf_wr_en),
    .wr_num  (retire.rf_wnum),
    .wr_data (retire.rf_wdata),
    .rs_num  (rs_num),
    .rt_num  (rt_num),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

endmodule

/* src/reg_file.sv */
`include "mycpu_defines.svh"

module reg_file (
  input  logic                     aclk,
  input  logic                     wr_en,
  input  logic [`MYCPU_REG_AW-1:0] wr_num,
  input  logic [`MYCPU_XLEN-1:0]   wr_data,
  input  logic [`MYCPU_REG_AW-1:0] rs_num,
  input  logic [`MYCPU_REG_AW-1:0] rt_num,
  output logic [`MYCPU_XLEN-1:0]   rs_data,
  output logic [`MYCPU_XLEN-1:0]   rt_data
);

  // r0 has no storage
  logic [`MYCPU_XLEN-1:0] regs [1:(1 << `MYCPU_REG_AW)-1];

  function automatic logic [`MYCPU_XLEN-1:0] read_port(
    input logic [`MYCPU_REG_AW-1:0] num
  );
    if (num == '0) return '0;
    // write in flight wins over the stored value
    if (wr_en && wr_num == num) return wr_data;
    return regs[num];
  endfunction

  always_ff @(posedge aclk) begin
    if (wr_en && wr_num != '0) begin
      regs[wr_num] <= wr_data;
    end
  end

  always_comb begin
    rs_data = read_port(rs_num);
    rt_data = read_port(rt_num);
  end

endmodule

/* src/result_stage.sv */
module result_stage (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  mycpu_pkg::retire_t  in_item,
  output logic                allowin,
  output logic                retire_valid,
  output mycpu_pkg::retire_t  retire,
  input  logic                retire_ready,
  output mycpu_pkg::fwd_t     fwd,
  output logic                wr_en
);

  logic valid;

  // holds the item unchanged until the retire port takes it
  assign allowin      = !valid || retire_ready;
  assign retire_valid = valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (allowin) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && allowin) begin
      retire <= in_item;
    end
  end

  assign wr_en = valid && retire_ready && (|retire.rf_wen);

  assign fwd.valid = valid && (|retire.rf_wen);
  assign fwd.num   = retire.rf_wnum;
  assign fwd.data  = retire.rf_wdata;

endmodule

/* tb/mycpu_chk.sv */
module mycpu_chk (
  input logic               aclk,
  input logic               rst_n,
  input logic               inst_allowin,
  input logic               de_valid,
  input logic               ex_valid,
  input logic               retire_valid,
  input mycpu_pkg::retire_t retire,
  input logic               retire_ready
);

  logic pipe_stalled;
  int   fail_count = 0;

  assign pipe_stalled = de_valid && ex_valid && retire_valid && !retire_ready;

  // stalled retire item must not move
  a_retire_hold: assert property (
    @(posedge aclk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire)
  ) else begin
    fail_count = fail_count + 1;
    $error("retire payload changed while retire_ready was low");
  end

  a_reset_idle: assert property (
    @(posedge aclk) !rst_n |=> !retire_valid
  ) else begin
    fail_count = fail_count + 1;
    $error("retire_valid high in the cycle after reset");
  end

  // fetch port closes only behind a full, stalled pipeline
  a_allowin_full: assert property (
    @(posedge aclk) disable iff (!rst_n) !inst_allowin |-> pipe_stalled
  ) else begin
    fail_count = fail_count + 1;
    $error("inst_allowin low while the pipeline still had room");
  end

endmodule

bind mycpu_top mycpu_chk u_chk (
  .aclk         (aclk),
  .rst_n        (rst_n),
  .inst_allowin (inst_allowin),
  .de_valid     (de_valid),
  .ex_valid     (ex_valid),
  .retire_valid (retire_valid),
  .retire       (retire),
  .retire_ready (retire_ready)
);

/* tb/mycpu_vectors.txt */
// columns: pc instr wnum wen wdata, all hex
// wnum and wdata are compared only when wen is nonzero
bfc00000 3c018000 01 f 80000000
bfc00004 34028765 02 f 00008765
bfc00008 2403fff0 03 f fffffff0
bfc0000c 3044ff0f 04 f 00008705
bfc00010 386500ff 05 f ffffff0f
bfc00014 2866fff8 06 f 00000001
bfc00018 2c270001 07 f 00000000
bfc0001c 24087fff 08 f 00007fff
bfc00020 01084821 09 f 0000fffe
bfc00024 01235023 0a f 0001000e
bfc00028 01495824 0b f 0000000e
bfc0002c 01616025 0c f 8000000e
bfc00030 01826826 0d f 8000876b
bfc00034 01a07027 0e f 7fff7894
bfc00038 01cd782a 0f f 00000000
bfc0003c 01cd802b 10 f 00000001
bfc00040 00108900 11 f 00000010
bfc00044 000190c3 12 f f0000000
bfc00048 00129a02 13 f 00f00000
bfc0004c 25000001 00 0 00000000
bfc00050 0011a021 14 f 00000010
bfc00054 8c220004 00 0 00000000
bfc00058 0040a825 15 f 00008765
bfc0005c 00221818 00 0 00000000
bfc00060 0060b021 16 f fffffff0

/* tb/tb_mycpu.sv */
`include "mycpu_defines.svh"

module tb_mycpu;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_VECS     = 64;
  localparam int VEC_WORDS    = 5;
  localparam int WAIT_LIMIT   = 200;

  // one expected retire, plus when it entered the fetch port
  typedef struct packed {
    logic [`MYCPU_XLEN-1:0] pc;
    logic [3:0]             wen;
    logic [4:0]             wnum;
    logic [`MYCPU_XLEN-1:0] wdata;
    logic [31:0]            accept_cyc;
    logic                   timed;
  } expect_t;

  logic               aclk;
  logic               rst_n;
  logic               inst_valid;
  mycpu_pkg::fetch_t  inst;
  logic               inst_allowin;
  logic               retire_valid;
  mycpu_pkg::retire_t retire;
  logic               retire_ready;

  logic [`MYCPU_XLEN-1:0] vec_mem [0:MAX_VECS*VEC_WORDS-1];
  expect_t                pending[$];
  int                     num_vecs;
  int                     retired = 0;
  int                     cycle = 0;
  integer                 seed;
  logic                   random_ready;

  mycpu_top DUT (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_allowin (inst_allowin),
    .retire_valid (retire_valid),
    .retire       (retire),
    .retire_ready (retire_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD/2) aclk = ~aclk;
  end

  // rising edges seen so far
  always @(posedge aclk) begin
    cycle <= cycle + 1;
  end

  task automatic stop_failed(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(
    input string                  name,
    input logic [`MYCPU_XLEN-1:0] got,
    input logic [`MYCPU_XLEN-1:0] exp
  );
    if (got !== exp) begin
      stop_failed($sformatf("[ERROR] %s got=%h exp=%h", name, got, exp));
    end
  endtask

  task automatic drive_ready();
    if (random_ready) begin
      if ($random(seed) & 1) retire_ready = !retire_ready;
    end else begin
      retire_ready = 1'b1;
    end
  endtask

  // called between falling and rising edge, once inputs have settled
  task automatic observe_retire();
    expect_t exp;
    if (retire_valid && retire_ready) begin
      if (pending.size() == 0) begin
        stop_failed("retire port delivered an item that was never sent");
      end
      exp = pending.pop_front();
      check_val("retire.pc", retire.pc, exp.pc);
      check_val("retire.rf_wen", retire.rf_wen, exp.wen);
      // number and data only mean something for a real write
      if (exp.wen != 0) begin
        check_val("retire.rf_wnum", retire.rf_wnum, exp.wnum);
        check_val("retire.rf_wdata", retire.rf_wdata, exp.wdata);
      end
      if (exp.timed) begin
        check_val("retire latency", cycle - exp.accept_cyc, 3);
      end
      retired = retired + 1;
    end
  endtask

  task automatic send_item(input int idx);
    int      waited;
    logic    accepted;
    expect_t exp;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge aclk);
      inst_valid  = 1'b1;
      inst.pc     = vec_mem[idx*VEC_WORDS];
      inst.instr  = vec_mem[idx*VEC_WORDS+1];
      drive_ready();
      #(CLK_PERIOD/4);
      observe_retire();
      // a free-running stream never sees back-pressure
      if (!random_ready) check_val("inst_allowin", inst_allowin, 1'b1);
      if (inst_allowin) begin
        accepted       = 1'b1;
        exp.pc         = vec_mem[idx*VEC_WORDS];
        exp.wnum       = vec_mem[idx*VEC_WORDS+2][4:0];
        exp.wen        = vec_mem[idx*VEC_WORDS+3][3:0];
        exp.wdata      = vec_mem[idx*VEC_WORDS+4];
        exp.accept_cyc = cycle;
        exp.timed      = !random_ready;
        pending.push_back(exp);
      end else begin
        waited = waited + 1;
        if (waited >= WAIT_LIMIT) begin
          stop_failed("fetch port did not accept an instruction within 200 cycles");
        end
      end
    end
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (pending.size() != 0) begin
      @(negedge aclk);
      inst_valid = 1'b0;
      drive_ready();
      #(CLK_PERIOD/4);
      observe_retire();
      waited = waited + 1;
      if (pending.size() != 0 && waited >= WAIT_LIMIT) begin
        stop_failed("last instruction did not retire within 200 cycles");
      end
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    inst_valid   = 1'b0;
    inst         = '0;
    retire_ready = 1'b1;
    random_ready = 1'b0;
    seed         = 12;
    $readmemh("tb/mycpu_vectors.txt", vec_mem);
    num_vecs = 0;
    while (num_vecs < MAX_VECS && !$isunknown(vec_mem[num_vecs*VEC_WORDS])) begin
      num_vecs = num_vecs + 1;
    end
    if (num_vecs == 0) begin
      stop_failed("no vectors could be read from tb/mycpu_vectors.txt");
    end
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;

    // back-to-back stream with the retire port always ready
    for (int i = 0; i < num_vecs; i++) begin
      send_item(i);
    end
    drain_pipeline();

    // same program again under random back-pressure
    random_ready = 1'b1;
    for (int i = 0; i < num_vecs; i++) begin
      send_item(i);
    end
    drain_pipeline();

    if (DUT.u_chk.fail_count != 0) begin
      stop_failed("a handshake assertion failed during the run");
    end else if (retired != 2 * num_vecs) begin
      stop_failed("number of retired items differs from the number sent");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule
